// ==== design/poker_pkg.sv ====
package poker_pkg;

    // ####################################################################
    // chip ledger
    // ####################################################################

    localparam int chip_w = 7;

    typedef logic [chip_w-1:0] chip_t;  // wraps modulo 128.

    localparam chip_t start_balance = chip_t'(49);
    localparam chip_t raise_step    = chip_t'(5);

    // ####################################################################
    // game flow
    // ####################################################################

    typedef enum logic [1:0] {
        preflop = 2'd0,
        flop    = 2'd1,
        turn    = 2'd2,
        river   = 2'd3
    } round_t;

    typedef enum logic {
        state_playing = 1'b0,
        state_cashout = 1'b1
    } game_state_t;

    // active low, bit order g f e d c b a.
    function automatic logic [6:0] seg_encode(input logic [3:0] digit);
        logic [6:0] pattern;
        case (digit)
            4'd0:    pattern = 7'b1000000;
            4'd1:    pattern = 7'b1111001;
            4'd2:    pattern = 7'b0100100;
            4'd3:    pattern = 7'b0110000;
            4'd4:    pattern = 7'b0011001;
            4'd5:    pattern = 7'b0010010;
            4'd6:    pattern = 7'b0000010;
            4'd7:    pattern = 7'b1111000;
            4'd8:    pattern = 7'b0000000;
            4'd9:    pattern = 7'b0010000;
            default: pattern = 7'b1111111;  // blank.
        endcase
        return pattern;
    endfunction

endpackage

// ==== design/button_conditioner.sv ====
`timescale 1ns/10ps

module button_conditioner #(
    parameter int DEBOUNCE_CYCLES = 500000
) (
    input  logic clk,
    input  logic call_p,
    input  logic raw,
    output logic level,
    output logic pulse
);

    localparam int               cnt_w    = $clog2(DEBOUNCE_CYCLES + 1);
    localparam logic [cnt_w-1:0] cnt_done = cnt_w'(DEBOUNCE_CYCLES);

    logic [1:0]       sync_q;
    logic [cnt_w-1:0] stable_cnt;
    logic             level_q;

    // two flops against metastability.
    always_ff @(posedge clk or posedge call_p) begin
        if (call_p) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[0], raw};
        end
    end

    // ####################################################################
    // debounce
    // ####################################################################

    always_ff @(posedge clk or posedge call_p) begin
        if (call_p) begin
            stable_cnt <= '0;
            level      <= 1'b0;
        end else if (sync_q[1] == level) begin
            stable_cnt <= '0;  // glitch over, start again.
        end else if (stable_cnt == cnt_done) begin
            level      <= sync_q[1];
            stable_cnt <= '0;
        end else begin
            stable_cnt <= stable_cnt + 1'b1;
        end
    end

    // one clock late, one clock wide.
    always_ff @(posedge clk or posedge call_p) begin
        if (call_p) begin
            level_q <= 1'b0;
            pulse   <= 1'b0;
        end else begin
            level_q <= level;
            pulse   <= level & ~level_q;
        end
    end

endmodule

// ==== design/betting_engine.sv ====
`timescale 1ns/10ps

module betting_engine import poker_pkg::*; (
    input  logic  clk,
    input  logic  call_p,
    input  logic  fold,
    input  logic  check_call,
    input  logic  raise,
    input  logic  cashout,
    output chip_t pot,
    output chip_t p1_balance,
    output chip_t p2_balance
);

    game_state_t state;
    game_state_t state_n;
    round_t      round;
    round_t      round_n;
    logic        cur_player;  // 0 is player one.
    logic        cur_player_n;
    logic        hand_odd;
    logic        hand_odd_n;
    chip_t       cur_bet;
    chip_t       cur_bet_n;
    chip_t       p1_bet;
    chip_t       p1_bet_n;
    chip_t       p2_bet;
    chip_t       p2_bet_n;
    chip_t       pot_n;
    chip_t       p1_balance_n;
    chip_t       p2_balance_n;

    logic  dealer;
    chip_t owed;
    chip_t pay;
    logic  close_round;
    logic  end_hand;

    assign dealer = hand_odd;  // player one deals even hands.
    assign owed   = cur_player ? (cur_bet - p2_bet) : (cur_bet - p1_bet);

    // ####################################################################
    // betting rules
    // ####################################################################

    always_comb begin
        state_n      = state;
        round_n      = round;
        cur_player_n = cur_player;
        hand_odd_n   = hand_odd;
        cur_bet_n    = cur_bet;
        p1_bet_n     = p1_bet;
        p2_bet_n     = p2_bet;
        pot_n        = pot;
        p1_balance_n = p1_balance;
        p2_balance_n = p2_balance;
        pay          = '0;
        close_round  = 1'b0;
        end_hand     = 1'b0;

        if (state == state_cashout) begin
            if (!cashout) begin
                // back to a fresh table.
                state_n      = state_playing;
                round_n      = preflop;
                cur_player_n = 1'b0;
                hand_odd_n   = 1'b0;
                cur_bet_n    = '0;
                p1_bet_n     = '0;
                p2_bet_n     = '0;
                pot_n        = '0;
                p1_balance_n = start_balance;
                p2_balance_n = start_balance;
            end
        end else if (cashout && round == preflop) begin
            state_n = state_cashout;
        end else if (fold) begin
            if (cur_player) begin
                p1_balance_n = p1_balance + pot;
            end else begin
                p2_balance_n = p2_balance + pot;
            end
            end_hand = 1'b1;
        end else if (check_call) begin
            if (cur_bet != '0) begin
                pay         = owed;
                close_round = 1'b1;
            end else if (cur_player != dealer) begin
                close_round = 1'b1;
            end else begin
                cur_player_n = ~cur_player;
            end
        end else if (raise) begin
            pay       = owed + raise_step;
            cur_bet_n = cur_bet + raise_step;
            if (cur_player) begin
                p2_bet_n = cur_bet_n;
            end else begin
                p1_bet_n = cur_bet_n;
            end
            cur_player_n = ~cur_player;
        end

        if (cur_player) begin
            p2_balance_n = p2_balance_n - pay;
        end else begin
            p1_balance_n = p1_balance_n - pay;
        end
        pot_n = pot_n + pay;

        if (close_round) begin
            cur_bet_n    = '0;
            p1_bet_n     = '0;
            p2_bet_n     = '0;
            cur_player_n = dealer;
            if (round == river) begin
                p1_balance_n = p1_balance_n + pot_n;  // showdown.
                end_hand     = 1'b1;
            end else begin
                round_n = round_t'(round + 2'd1);
            end
        end

        if (end_hand) begin
            pot_n        = '0;
            cur_bet_n    = '0;
            p1_bet_n     = '0;
            p2_bet_n     = '0;
            hand_odd_n   = ~hand_odd;
            cur_player_n = ~hand_odd;  // new dealer opens.
            round_n      = preflop;
        end
    end

    always_ff @(posedge clk or posedge call_p) begin
        if (call_p) begin
            state      <= state_playing;
            round      <= preflop;
            cur_player <= 1'b0;
            hand_odd   <= 1'b0;
            cur_bet    <= '0;
            p1_bet     <= '0;
            p2_bet     <= '0;
            pot        <= '0;
            p1_balance <= start_balance;
            p2_balance <= start_balance;
        end else begin
            state      <= state_n;
            round      <= round_n;
            cur_player <= cur_player_n;
            hand_odd   <= hand_odd_n;
            cur_bet    <= cur_bet_n;
            p1_bet     <= p1_bet_n;
            p2_bet     <= p2_bet_n;
            pot        <= pot_n;
            p1_balance <= p1_balance_n;
            p2_balance <= p2_balance_n;
        end
    end

endmodule

// ==== design/digit_scanner.sv ====
`timescale 1ns/10ps

module digit_scanner import poker_pkg::*; #(
    parameter int DIGITS      = 4,
    parameter int SCAN_CYCLES = 50000,
    parameter bit SEG_INVERT  = 1'b0
) (
    input  logic              clk,
    input  logic              call_p,
    input  chip_t             value,
    output logic [6:0]        seg,
    output logic [DIGITS-1:0] an
);

    localparam int               cnt_w     = $clog2(SCAN_CYCLES + 1);
    localparam int               idx_w     = (DIGITS > 1) ? $clog2(DIGITS) : 1;
    localparam logic [cnt_w-1:0] scan_last = cnt_w'(SCAN_CYCLES - 1);
    localparam logic [idx_w-1:0] idx_last  = idx_w'(DIGITS - 1);
    localparam chip_t            ten       = chip_t'(10);

    logic [cnt_w-1:0] scan_cnt;
    logic [idx_w-1:0] digit_idx;
    chip_t            ones;
    chip_t            tens;
    logic [3:0]       digit;
    logic [6:0]       pattern;

    // ####################################################################
    // scan timing
    // ####################################################################

    always_ff @(posedge clk or posedge call_p) begin
        if (call_p) begin
            scan_cnt  <= '0;
            digit_idx <= '0;
        end else if (scan_cnt == scan_last) begin
            scan_cnt <= '0;
            if (digit_idx == idx_last) begin
                digit_idx <= '0;
            end else begin
                digit_idx <= digit_idx + 1'b1;
            end
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    // ####################################################################
    // digit select and decode
    // ####################################################################

    assign ones = value % ten;
    assign tens = value / ten;  // above 99 this blanks.

    always_comb begin
        if (digit_idx == '0) begin
            digit = ones[3:0];
        end else if (digit_idx == idx_w'(1)) begin
            digit = tens[3:0];
        end else begin
            digit = 4'd0;  // upper places.
        end
    end

    assign pattern = seg_encode(digit);
    assign seg     = SEG_INVERT ? ~pattern : pattern;

    always_comb begin
        an            = '1;
        an[digit_idx] = 1'b0;  // active low one-hot.
    end

endmodule

// ==== design/poker_top.sv ====
`timescale 1ns/10ps

module poker_top import poker_pkg::*; #(
    parameter int DEBOUNCE_CYCLES = 500000,
    parameter int SCAN_CYCLES     = 50000
) (
    input  logic       clk,
    input  logic       call_p,
    input  logic       btn_fold,
    input  logic       btn_check_call,
    input  logic       btn_raise,
    input  logic       sw_cashout,
    output logic [6:0] pot_seg,
    output logic [3:0] pot_an,
    output logic [6:0] p1_seg,
    output logic [1:0] p1_an,
    output logic [6:0] p2_seg,
    output logic [1:0] p2_an
);

    logic  fold_pulse;
    logic  check_call_pulse;
    logic  raise_pulse;
    logic  cashout_level;
    chip_t pot;
    chip_t p1_balance;
    chip_t p2_balance;

    // ####################################################################
    // input conditioning
    // ####################################################################

    button_conditioner #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_fold (
        .clk    (clk),
        .call_p (call_p),
        .raw    (btn_fold),
        .level  (),
        .pulse  (fold_pulse)
    );

    button_conditioner #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_check_call (
        .clk    (clk),
        .call_p (call_p),
        .raw    (btn_check_call),
        .level  (),
        .pulse  (check_call_pulse)
    );

    button_conditioner #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_raise (
        .clk    (clk),
        .call_p (call_p),
        .raw    (btn_raise),
        .level  (),
        .pulse  (raise_pulse)
    );

    // switch, so the level matters here.
    button_conditioner #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_cashout (
        .clk    (clk),
        .call_p (call_p),
        .raw    (sw_cashout),
        .level  (cashout_level),
        .pulse  ()
    );

    betting_engine u_engine (
        .clk        (clk),
        .call_p     (call_p),
        .fold       (fold_pulse),
        .check_call (check_call_pulse),
        .raise      (raise_pulse),
        .cashout    (cashout_level),
        .pot        (pot),
        .p1_balance (p1_balance),
        .p2_balance (p2_balance)
    );

    // ####################################################################
    // displays
    // ####################################################################

    digit_scanner #(.DIGITS(4), .SCAN_CYCLES(SCAN_CYCLES), .SEG_INVERT(1'b0)) u_pot_disp (
        .clk    (clk),
        .call_p (call_p),
        .value  (pot),
        .seg    (pot_seg),
        .an     (pot_an)
    );

    digit_scanner #(.DIGITS(2), .SCAN_CYCLES(SCAN_CYCLES), .SEG_INVERT(1'b1)) u_p1_disp (
        .clk    (clk),
        .call_p (call_p),
        .value  (p1_balance),
        .seg    (p1_seg),
        .an     (p1_an)
    );

    digit_scanner #(.DIGITS(2), .SCAN_CYCLES(SCAN_CYCLES), .SEG_INVERT(1'b1)) u_p2_disp (
        .clk    (clk),
        .call_p (call_p),
        .value  (p2_balance),
        .seg    (p2_seg),
        .an     (p2_an)
    );

endmodule

// ==== tb/poker_tb_tasks.svh ====
// ####################################################################
// reporting and display readback
// ####################################################################

task automatic stop_failed();
    $display("Checks failed");
    $fatal(1);
endtask

task automatic check_value(input string name, input int expected, input int actual);
    if (expected != actual) begin
        $display("MISMATCH %s expected %0d actual %0d", name, expected, actual);
        stop_failed();
    end
endtask

// active low in g f e d c b a order.
function automatic int decode_seg(input logic [6:0] seg);
    int digit;
    case (seg)
        7'b1000000: digit = 0;
        7'b1111001: digit = 1;
        7'b0100100: digit = 2;
        7'b0110000: digit = 3;
        7'b0011001: digit = 4;
        7'b0010010: digit = 5;
        7'b0000010: digit = 6;
        7'b1111000: digit = 7;
        7'b0000000: digit = 8;
        7'b0010000: digit = 9;
        default:    digit = -1;
    endcase
    return digit;
endfunction

// which is 0 for the pot, 1 and 2 for the players.
task automatic read_digit(input int which, input logic [1:0] idx, output int digit);
    logic [3:0] an;
    logic [6:0] seg;
    an  = '1;
    seg = '1;
    while (an[idx] !== 1'b0) begin
        @(negedge clk);
        an  = (which == 0) ? pot_an : {2'b11, (which == 1) ? p1_an : p2_an};
        seg = (which == 0) ? pot_seg : ~((which == 1) ? p1_seg : p2_seg);  // players invert.
    end
    digit = decode_seg(seg);
    if (digit < 0) begin
        $display("display %0d digit %0d shows a pattern that is not a decimal digit", which, idx);
        stop_failed();
    end
endtask

task automatic read_value(input int which, output int value);
    int tens;
    int ones;
    read_digit(which, 2'd1, tens);
    read_digit(which, 2'd0, ones);
    value = tens * 10 + ones;
endtask

task automatic check_displays(input string name);
    int value;
    int upper;
    read_value(0, value);
    check_value({name, " pot"}, m_pot, value);
    read_value(1, value);
    check_value({name, " p1 balance"}, m_bal[0], value);
    read_value(2, value);
    check_value({name, " p2 balance"}, m_bal[1], value);
    read_digit(0, 2'd2, upper);
    check_value({name, " pot digit 2"}, 0, upper);
    read_digit(0, 2'd3, upper);
    check_value({name, " pot top digit"}, 0, upper);
endtask

// ####################################################################
// stimulus and reference model
// ####################################################################

task automatic drive_button(input int which, input logic value);
    case (which)
        act_fold:  btn_fold = value;
        act_check: btn_check_call = value;
        default:   btn_raise = value;
    endcase
endtask

task automatic press_button(input int which, input int hold);
    @(negedge clk);
    drive_button(which, 1'b1);
    repeat (hold) @(negedge clk);
    drive_button(which, 1'b0);
    repeat (settle_cycles) @(negedge clk);
endtask

task automatic model_reset();
    m_pot     = 0;
    m_bal[0]  = start_chips;
    m_bal[1]  = start_chips;
    m_bet[0]  = 0;
    m_bet[1]  = 0;
    m_cur_bet = 0;
    m_round   = 0;
    m_player  = 1'b0;
    m_dealer  = 1'b0;
    m_cashout = 1'b0;
endtask

task automatic pay_chips(input int amount);
    m_bal[m_player] = (m_bal[m_player] - amount) & 127;  // chips wrap at 128.
    m_pot           = (m_pot + amount) & 127;
endtask

task automatic end_hand();
    m_pot     = 0;
    m_cur_bet = 0;
    m_bet[0]  = 0;
    m_bet[1]  = 0;
    m_dealer  = ~m_dealer;
    m_player  = m_dealer;
    m_round   = 0;
endtask

task automatic close_round();
    m_cur_bet = 0;
    m_bet[0]  = 0;
    m_bet[1]  = 0;
    m_player  = m_dealer;
    if (m_round == 3) begin
        m_bal[0] = (m_bal[0] + m_pot) & 127;  // player one takes the showdown pot.
        end_hand();
    end else begin
        m_round = m_round + 1;
    end
endtask

task automatic act(input int which);
    press_button(which, 2 * debounce_cycles);
    if (!m_cashout) begin
        case (which)
            act_fold: begin
                m_bal[~m_player] = (m_bal[~m_player] + m_pot) & 127;
                end_hand();
            end
            act_check: begin
                if (m_cur_bet != 0) begin
                    pay_chips(m_cur_bet - m_bet[m_player]);
                    close_round();
                end else if (m_player != m_dealer) begin
                    close_round();
                end else begin
                    m_player = ~m_player;
                end
            end
            default: begin
                pay_chips(m_cur_bet - m_bet[m_player] + raise_chips);
                m_cur_bet       = m_cur_bet + raise_chips;
                m_bet[m_player] = m_cur_bet;
                m_player        = ~m_player;
            end
        endcase
    end
endtask

// ####################################################################
// directed tests
// ####################################################################

task automatic reset_values();
    check_displays("reset_values");
endtask

task automatic raise_then_call();
    act(act_raise);
    act(act_check);
    check_displays("raise_then_call");
    act(act_raise);  // dealer opens the flop.
    act(act_fold);
    check_displays("raise_then_call flop");
endtask

task automatic fold_gives_pot();
    act(act_raise);
    act(act_fold);
    check_displays("fold_gives_pot");
    act(act_check);
    act(act_check);
    act(act_raise);
    act(act_fold);
    check_displays("fold_gives_pot next hand");
endtask

task automatic showdown_at_river();
    repeat (4) act(act_check);  // preflop and flop.
    act(act_raise);
    act(act_check);
    act(act_check);
    act(act_check);
    check_displays("showdown_at_river");
endtask

task automatic cashout_hold();
    @(negedge clk);
    sw_cashout = 1'b1;
    repeat (settle_cycles) @(negedge clk);
    m_cashout = 1'b1;  // still preflop so the table locks.
    act(act_raise);
    act(act_check);
    check_displays("cashout_hold");
    @(negedge clk);
    sw_cashout = 1'b0;
    repeat (settle_cycles) @(negedge clk);
    model_reset();
    check_displays("cashout_release");
endtask

task automatic short_glitch();
    act(act_raise);
    check_displays("short_glitch before");
    press_button(act_fold, debounce_cycles - 1);
    check_displays("short_glitch after");
endtask

// ==== tb/poker_tb.sv ====
`timescale 1ns/10ps

module poker_tb;

    localparam int debounce_cycles = 4;
    localparam int scan_cycles     = 3;
    localparam int clk_period      = 100;
    localparam int test_count      = 6;
    localparam int settle_cycles   = 4 * debounce_cycles + 4;  // release through the debounce.
    localparam int start_chips     = 49;
    localparam int raise_chips     = 5;

    localparam int act_fold  = 0;
    localparam int act_check = 1;
    localparam int act_raise = 2;

    logic       clk;
    logic       call_p;
    logic       btn_fold;
    logic       btn_check_call;
    logic       btn_raise;
    logic       sw_cashout;
    logic [6:0] pot_seg;
    logic [3:0] pot_an;
    logic [6:0] p1_seg;
    logic [1:0] p1_an;
    logic [6:0] p2_seg;
    logic [1:0] p2_an;

    // reference model of the table, index 0 is player one.
    int m_pot;
    int m_bal[2];
    int m_bet[2];
    int m_cur_bet;
    int m_round;
    bit m_player;
    bit m_dealer;
    bit m_cashout;

    `include "poker_tb_tasks.svh"

    poker_top #(
        .DEBOUNCE_CYCLES (debounce_cycles),
        .SCAN_CYCLES     (scan_cycles)
    ) UUT (
        .clk            (clk),
        .call_p         (call_p),
        .btn_fold       (btn_fold),
        .btn_check_call (btn_check_call),
        .btn_raise      (btn_raise),
        .sw_cashout     (sw_cashout),
        .pot_seg        (pot_seg),
        .pot_an         (pot_an),
        .p1_seg         (p1_seg),
        .p1_an          (p1_an),
        .p2_seg         (p2_seg),
        .p2_an          (p2_an)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // watchdog.
    initial begin
        #(test_count * 2000 * clk_period);
        $display("run timed out after %0d clocks", test_count * 2000);
        stop_failed();
    end

    initial begin
        call_p         = 1'b1;
        btn_fold       = 1'b0;
        btn_check_call = 1'b0;
        btn_raise      = 1'b0;
        sw_cashout     = 1'b0;
        model_reset();
        repeat (4) @(posedge clk);
        @(negedge clk);
        call_p = 1'b0;

        reset_values();
        raise_then_call();
        fold_gives_pot();
        showdown_at_river();
        cashout_hold();
        short_glitch();

        $display("All checks passed");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+tb
design/poker_pkg.sv
design/button_conditioner.sv
design/betting_engine.sv
design/digit_scanner.sv
design/poker_top.sv
tb/poker_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module poker_tb -f build.f --Mdir obj_dir -o poker_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/poker_sim
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "simulation failed with status $sim_status"
    exit $sim_status
fi

echo "simulation finished cleanly"
exit 0
